// File: build.f
hdl/safe_bus_pkg.sv
hdl/redundancy_if.sv
hdl/lockstep_delay.sv
hdl/tmr_voter.sv
hdl/dmr_comparator.sv
hdl/bus_router.sv
hdl/safe_bus_top.sv
bench/tb_clock_gen.sv
bench/safe_bus_tb.sv

// File: bench/safe_bus_testdata.txt
# mode master pair hart_req0 hart_req1 hart_req2 mem_rsp0 mem_rsp1 mem_rsp2 exp_mem_req0..2
# exp_hart_rsp0..2 exp_tmr_error exp_tmr_error_id exp_dmr_error, all fields hex
# independent mode after reset
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 2f0000100000000000 3f0000200012345678 230000300000000000 3aaaa0001 3bbbb0002 3cccc0003 2f0000100000000000 3f0000200012345678 230000300000000000 3aaaa0001 3bbbb0002 3cccc0003 0 0 0
0 0 0 2f0000400000000000 0 3c0000500011112222 200000000 0 3bbbb0002 2f0000400000000000 0 3c0000500011112222 200000000 0 3bbbb0002 0 0 0
0 2 0 2f0000100000000000 2f0000100000000000 2f0000100000000000 3aaaa0001 3bbbb0002 3cccc0003 2f0000100000000000 2f0000100000000000 2f0000100000000000 3aaaa0001 3bbbb0002 3cccc0003 0 0 0
# TMR with latched master 2, master_i changes are ignored
1 2 0 2f0000100000000000 2f0000100000000000 2f0000100000000000 3aaaa0001 3bbbb0002 3cccc0003 0 0 2f0000100000000000 3cccc0003 3cccc0003 3cccc0003 0 0 0
1 0 0 3f0000200012345678 3f0000200012345678 3f0000200012345678 3aaaa0001 3bbbb0002 3cccc0003 0 0 3f0000200012345678 3cccc0003 3cccc0003 3cccc0003 0 0 0
1 1 0 230000300000000000 230000300000000000 230000300000000000 200000000 3aaaa0001 0 0 0 230000300000000000 0 0 0 0 0 0
# TMR with one deviating hart, then all three different
1 1 0 2f0000100000000000 2f0000100000000000 3f00002000deadbeef 3aaaa0001 3bbbb0002 3cccc0003 0 0 2f0000100000000000 3cccc0003 3cccc0003 3cccc0003 1 4 0
1 1 0 3f00002000deadbeef 3f0000200012345678 3f0000200012345678 3aaaa0001 3bbbb0002 3cccc0003 0 0 3f0000200012345678 3cccc0003 3cccc0003 3cccc0003 1 1 0
1 1 0 3f0000200012345678 3f00002000deadbeef 3f0000200012345678 3aaaa0001 3bbbb0002 3cccc0003 0 0 3f0000200012345678 3cccc0003 3cccc0003 3cccc0003 1 2 0
1 1 0 2f0000100000000000 3f0000200012345678 230000300000000000 3aaaa0001 3bbbb0002 3cccc0003 0 0 2f0000100000000000 3cccc0003 3cccc0003 3cccc0003 1 0 0
1 1 0 0 0 0 3aaaa0001 3bbbb0002 3cccc0003 0 0 0 3cccc0003 3cccc0003 3cccc0003 0 0 0
# back to independent to latch master 1, then TMR again
0 1 0 2f0000100000000000 3f0000200012345678 230000300000000000 3aaaa0001 3bbbb0002 3cccc0003 2f0000100000000000 3f0000200012345678 230000300000000000 3aaaa0001 3bbbb0002 3cccc0003 0 0 0
1 1 0 2f0000400000000000 2f0000400000000000 2f0000400000000000 3aaaa0001 3bbbb0002 3cccc0003 0 2f0000400000000000 0 3bbbb0002 3bbbb0002 3bbbb0002 0 0 0
1 2 0 2f0000400000000000 3c0000500011112222 2f0000400000000000 3aaaa0001 3bbbb0002 3cccc0003 0 2f0000400000000000 0 3bbbb0002 3bbbb0002 3bbbb0002 1 2 0
# DMR pair 1-2, shadow hart 2 runs two cycles behind, hart 0 independent
2 0 1 3c0000500011112222 2f0000100000000000 0 3cccc0003 3aaaa0001 3bbbb0002 3c0000500011112222 0 0 3cccc0003 3aaaa0001 3aaaa0001 0 0 0
2 0 1 0 3f0000200012345678 0 0 200000000 3bbbb0002 0 0 0 0 200000000 200000000 0 0 0
2 0 1 2f0000400000000000 230000300000000000 2f0000100000000000 200000000 3aaaa0001 3cccc0003 2f0000400000000000 2f0000100000000000 0 200000000 3aaaa0001 3aaaa0001 0 0 0
2 0 1 0 2f0000400000000000 3f0000200012345678 0 3bbbb0002 0 0 3f0000200012345678 0 0 3bbbb0002 3bbbb0002 0 0 0
2 0 1 2f0000100000000000 0 230000300000000000 3aaaa0001 3cccc0003 3bbbb0002 2f0000100000000000 230000300000000000 0 3aaaa0001 3cccc0003 3cccc0003 0 0 0
2 0 1 0 0 2f0000400000000000 0 3aaaa0001 0 0 2f0000400000000000 0 0 3aaaa0001 3aaaa0001 0 0 0
2 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# DMR mismatches and a low gnt with rvalid to both harts of the pair
2 0 1 0 2f0000100000000000 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 1 0 3f0000200012345678 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 1 0 0 3f00002000deadbeef 0 3bbbb0002 0 0 2f0000100000000000 0 0 3bbbb0002 3bbbb0002 0 0 1
2 0 1 0 0 3f0000200012345678 3aaaa0001 1cafef00d 0 0 3f0000200012345678 0 3aaaa0001 1cafef00d 1cafef00d 0 0 0
2 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 1 0 0 2f0000100000000000 0 0 0 0 0 0 0 0 0 0 0 1
2 0 1 0 0 5 0 0 0 0 0 0 0 0 0 0 0 0
# DMR pair 0-2, hart 1 independent
2 0 2 2f0000100000000000 2f0000400000000000 0 3aaaa0001 3bbbb0002 3cccc0003 0 2f0000400000000000 0 3aaaa0001 3bbbb0002 3aaaa0001 0 0 0
2 0 2 3f0000200012345678 0 0 200000000 0 0 0 0 0 200000000 0 200000000 0 0 0
2 0 2 0 3c0000500011112222 2f0000100000000000 3aaaa0001 3cccc0003 0 2f0000100000000000 3c0000500011112222 0 3aaaa0001 3cccc0003 3aaaa0001 0 0 0
2 0 2 0 0 3f0000200012345678 3bbbb0002 0 0 3f0000200012345678 0 0 3bbbb0002 0 3bbbb0002 0 0 0
2 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# unused mode code acts as independent, unused pair code acts as pair 0-1
3 1 0 2f0000100000000000 3f0000200012345678 230000300000000000 3aaaa0001 3bbbb0002 3cccc0003 2f0000100000000000 3f0000200012345678 230000300000000000 3aaaa0001 3bbbb0002 3cccc0003 0 0 0
1 0 0 230000300000000000 230000300000000000 230000300000000000 3aaaa0001 3bbbb0002 3cccc0003 0 230000300000000000 0 3bbbb0002 3bbbb0002 3bbbb0002 0 0 0
2 0 3 2f0000100000000000 0 2f0000400000000000 3aaaa0001 3bbbb0002 3cccc0003 0 0 2f0000400000000000 3aaaa0001 3aaaa0001 3cccc0003 0 0 0
2 0 3 0 0 0 200000000 3aaaa0001 3bbbb0002 0 0 0 200000000 200000000 3bbbb0002 0 0 0
2 0 3 0 2f0000100000000000 0 3aaaa0001 0 0 2f0000100000000000 0 0 3aaaa0001 3aaaa0001 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: bench/safe_bus_tb.sv
/*
 * Vector-driven testbench for the bus safety fabric, one cycle per
 * vector line, with inputs, expected memory requests, hart responses
 * and error flags read from the test data file
 */
`timescale 1ns/1ps

module safe_bus_tb;

    localparam int    NCYCLES       = 2;
    localparam int    RESET_TIMEOUT = 50;
    localparam int    MAX_VECTORS   = 500;
    localparam string VECTOR_FILE   = "bench/safe_bus_testdata.txt";

    logic clk;
    logic rst_n;

    safe_bus_pkg::obi_req_t [safe_bus_pkg::NHARTS-1:0] hart_req;
    safe_bus_pkg::obi_rsp_t [safe_bus_pkg::NHARTS-1:0] hart_rsp;
    safe_bus_pkg::obi_req_t [safe_bus_pkg::NHARTS-1:0] mem_req;
    safe_bus_pkg::obi_rsp_t [safe_bus_pkg::NHARTS-1:0] mem_rsp;
    safe_bus_pkg::safety_mode_e                        mode;
    logic [1:0]                                        master;
    safe_bus_pkg::dmr_pair_e                           pair;
    logic                                              tmr_error;
    logic [2:0]                                        tmr_error_id;
    logic                                              dmr_error;

    // Fields of the current vector line
    logic [1:0]  mode_v;
    logic [1:0]  master_v;
    logic [1:0]  pair_v;
    logic [69:0] hart_req_v [3];
    logic [33:0] mem_rsp_v [3];
    logic [69:0] exp_mem_req [3];
    logic [33:0] exp_hart_rsp [3];
    logic        exp_tmr_error;
    logic [2:0]  exp_tmr_error_id;
    logic        exp_dmr_error;
    int          vec_num;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (8)
    ) tb_clock_gen_inst (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    safe_bus_top #(
        .NCYCLES (NCYCLES)
    ) safe_bus_top_inst (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .hart_req_i     (hart_req),
        .hart_rsp_o     (hart_rsp),
        .mem_req_o      (mem_req),
        .mem_rsp_i      (mem_rsp),
        .mode_i         (mode),
        .master_i       (master),
        .pair_i         (pair),
        .tmr_error_o    (tmr_error),
        .tmr_error_id_o (tmr_error_id),
        .dmr_error_o    (dmr_error)
    );

    task automatic abort_run(input string reason);
        $display("%s (vector %0d)", reason, vec_num);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [69:0] expected,
                                 input logic [69:0] actual);
        assert (actual === expected) else begin
            $display("** Error: %s expected 0x%0h, got 0x%0h at vector %0d",
                     name, expected, actual, vec_num);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic apply_inputs();
        mode   = safe_bus_pkg::safety_mode_e'(mode_v);
        master = master_v;
        pair   = safe_bus_pkg::dmr_pair_e'(pair_v);
        for (int k = 0; k < safe_bus_pkg::NHARTS; k++) begin
            hart_req[k] = hart_req_v[k];
            mem_rsp[k]  = mem_rsp_v[k];
        end
    endtask

    task automatic check_outputs();
        for (int k = 0; k < safe_bus_pkg::NHARTS; k++) begin
            compare_value($sformatf("mem_req_o[%0d]", k), exp_mem_req[k], mem_req[k]);
            compare_value($sformatf("hart_rsp_o[%0d]", k), exp_hart_rsp[k], hart_rsp[k]);
        end
        compare_value("tmr_error_o", exp_tmr_error, tmr_error);
        compare_value("tmr_error_id_o", exp_tmr_error_id, tmr_error_id);
        compare_value("dmr_error_o", exp_dmr_error, dmr_error);
    endtask

    initial begin : main
        int    fd;
        int    n_fields;
        int    cycles;
        string line;

        hart_req = '0;
        mem_rsp  = '0;
        mode     = safe_bus_pkg::MODE_INDEPENDENT;
        master   = 2'd0;
        pair     = safe_bus_pkg::PAIR_01;
        vec_num  = 0;

        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                abort_run("reset was not released in time");
            end
        end

        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            abort_run("the vector file could not be opened");
        end

        cycles = 0;
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) begin
                break;
            end
            // Blank lines and comment lines carry no vector
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n_fields = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                mode_v, master_v, pair_v,
                hart_req_v[0], hart_req_v[1], hart_req_v[2],
                mem_rsp_v[0], mem_rsp_v[1], mem_rsp_v[2],
                exp_mem_req[0], exp_mem_req[1], exp_mem_req[2],
                exp_hart_rsp[0], exp_hart_rsp[1], exp_hart_rsp[2],
                exp_tmr_error, exp_tmr_error_id, exp_dmr_error);
            if (n_fields != 18) begin
                abort_run("a vector line does not hold all 18 fields");
            end
            vec_num++;

            // Drive just after the edge, sample just before the next one
            @(posedge clk);
            #2;
            apply_inputs();
            #16;
            check_outputs();

            cycles++;
            if (cycles > MAX_VECTORS) begin
                abort_run("the vector loop ran past its cycle limit");
            end
        end
        $fclose(fd);

        if (vec_num > 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("no vectors were found in the vector file");
        end
    end

endmodule

// File: bench/tb_clock_gen.sv
/*
 * Testbench clock source and active-low reset pulse
 */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// File: hdl/safe_bus_top.sv
/*
 * Bus safety fabric top level with TMR voter, DMR comparator and router
 */
`timescale 1ns/1ps

module safe_bus_top #(
    parameter int NCYCLES = 1
) (
    input  logic                                              clk_i,
    input  logic                                              rst_ni,
    // Hart side
    input  safe_bus_pkg::obi_req_t [safe_bus_pkg::NHARTS-1:0] hart_req_i,
    output safe_bus_pkg::obi_rsp_t [safe_bus_pkg::NHARTS-1:0] hart_rsp_o,
    // Memory side
    output safe_bus_pkg::obi_req_t [safe_bus_pkg::NHARTS-1:0] mem_req_o,
    input  safe_bus_pkg::obi_rsp_t [safe_bus_pkg::NHARTS-1:0] mem_rsp_i,
    // Mode control
    input  safe_bus_pkg::safety_mode_e                        mode_i,
    input  logic [1:0]                                        master_i,
    input  safe_bus_pkg::dmr_pair_e                           pair_i,
    // Error reporting
    output logic                                              tmr_error_o,
    output logic [2:0]                                        tmr_error_id_o,
    output logic                                              dmr_error_o
);

    redundancy_if chk_if ();

    tmr_voter tmr_voter_inst (
        .hart_req_i (hart_req_i),
        .mode_i     (mode_i),
        .chk        (chk_if.voter_mp)
    );

    dmr_comparator #(
        .NCYCLES (NCYCLES)
    ) dmr_comparator_inst (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .hart_req_i (hart_req_i),
        .mode_i     (mode_i),
        .pair_i     (pair_i),
        .chk        (chk_if.comparator_mp)
    );

    bus_router bus_router_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .hart_req_i     (hart_req_i),
        .hart_rsp_o     (hart_rsp_o),
        .mem_req_o      (mem_req_o),
        .mem_rsp_i      (mem_rsp_i),
        .mode_i         (mode_i),
        .master_i       (master_i),
        .pair_i         (pair_i),
        .chk            (chk_if.router_mp),
        .tmr_error_o    (tmr_error_o),
        .tmr_error_id_o (tmr_error_id_o),
        .dmr_error_o    (dmr_error_o)
    );

endmodule

// File: hdl/bus_router.sv
/*
 * Master register and per-mode routing of hart requests to the memory
 * ports and of memory responses back to the harts
 */
`timescale 1ns/1ps

module bus_router (
    input  logic                                              clk_i,
    input  logic                                              rst_ni,
    input  safe_bus_pkg::obi_req_t [safe_bus_pkg::NHARTS-1:0] hart_req_i,
    output safe_bus_pkg::obi_rsp_t [safe_bus_pkg::NHARTS-1:0] hart_rsp_o,
    output safe_bus_pkg::obi_req_t [safe_bus_pkg::NHARTS-1:0] mem_req_o,
    input  safe_bus_pkg::obi_rsp_t [safe_bus_pkg::NHARTS-1:0] mem_rsp_i,
    input  safe_bus_pkg::safety_mode_e                        mode_i,
    input  logic [1:0]                                        master_i,
    input  safe_bus_pkg::dmr_pair_e                           pair_i,
    redundancy_if.router_mp                                   chk,
    output logic                                              tmr_error_o,
    output logic [2:0]                                        tmr_error_id_o,
    output logic                                              dmr_error_o
);

    logic [1:0] master_q;
    logic [1:0] lead_idx;
    logic [1:0] shadow_idx;
    logic       indep_mode;

    assign indep_mode = (mode_i != safe_bus_pkg::MODE_TMR)
                     && (mode_i != safe_bus_pkg::MODE_DMR);

    // Master only follows master_i outside the redundant modes
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            master_q <= 2'd0;
        end else if (indep_mode) begin
            // Index 3 has no hart, falls back to hart 0
            if (master_i < safe_bus_pkg::NHARTS) begin
                master_q <= master_i;
            end else begin
                master_q <= 2'd0;
            end
        end
    end

    assign lead_idx   = safe_bus_pkg::pair_lead(pair_i);
    assign shadow_idx = safe_bus_pkg::pair_shadow(pair_i);

    always_comb begin
        // Independent routing as the base case
        mem_req_o  = hart_req_i;
        hart_rsp_o = mem_rsp_i;

        case (mode_i)
            safe_bus_pkg::MODE_TMR: begin
                mem_req_o           = '0;
                mem_req_o[master_q] = chk.tmr_req;
                for (int k = 0; k < safe_bus_pkg::NHARTS; k++) begin
                    hart_rsp_o[k] = mem_rsp_i[master_q];
                end
            end
            safe_bus_pkg::MODE_DMR: begin
                // Third hart keeps its own port
                mem_req_o[lead_idx]   = chk.dmr_req;
                mem_req_o[shadow_idx] = '0;
                hart_rsp_o[lead_idx]   = mem_rsp_i[lead_idx];
                hart_rsp_o[shadow_idx] = mem_rsp_i[lead_idx];
            end
            default: begin
            end
        endcase
    end

    assign tmr_error_o    = chk.tmr_error;
    assign tmr_error_id_o = chk.tmr_error_id;
    assign dmr_error_o    = chk.dmr_error;

endmodule

// File: hdl/dmr_comparator.sv
/*
 * DMR pair selection, lockstep delay of the lead request and
 * comparison against the live shadow request
 */
`timescale 1ns/1ps

module dmr_comparator #(
    parameter int NCYCLES = 1
) (
    input  logic                                              clk_i,
    input  logic                                              rst_ni,
    input  safe_bus_pkg::obi_req_t [safe_bus_pkg::NHARTS-1:0] hart_req_i,
    input  safe_bus_pkg::safety_mode_e                        mode_i,
    input  safe_bus_pkg::dmr_pair_e                           pair_i,
    redundancy_if.comparator_mp                               chk
);

    logic [1:0]             lead_idx;
    logic [1:0]             shadow_idx;
    logic                   dmr_mode;
    safe_bus_pkg::obi_req_t lead_req;
    safe_bus_pkg::obi_req_t shadow_req;
    safe_bus_pkg::obi_req_t lead_delayed;

    assign dmr_mode   = (mode_i == safe_bus_pkg::MODE_DMR);
    assign lead_idx   = safe_bus_pkg::pair_lead(pair_i);
    assign shadow_idx = safe_bus_pkg::pair_shadow(pair_i);

    assign lead_req   = hart_req_i[lead_idx];
    assign shadow_req = hart_req_i[shadow_idx];

    // Shadow hart runs NCYCLES behind the lead
    lockstep_delay #(
        .NCYCLES (NCYCLES)
    ) lockstep_delay_inst (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (lead_req),
        .enable_i (dmr_mode),
        .req_o    (lead_delayed)
    );

    assign chk.dmr_req = lead_delayed;

    // Idle cycles on both sides never count as a mismatch
    assign chk.dmr_error = dmr_mode
                        && (lead_delayed != shadow_req)
                        && (lead_delayed.req || shadow_req.req);

endmodule

// File: hdl/tmr_voter.sv
/*
 * Majority vote over the three hart requests, with mismatch flag
 * and one-hot identity of the deviating hart
 */
`timescale 1ns/1ps

module tmr_voter (
    input  safe_bus_pkg::obi_req_t [safe_bus_pkg::NHARTS-1:0] hart_req_i,
    input  safe_bus_pkg::safety_mode_e                        mode_i,
    redundancy_if.voter_mp                                    chk
);

    logic eq_01;
    logic eq_12;
    logic eq_02;
    logic tmr_mode;
    logic [2:0] error_id;

    // Whole struct compared, not only the payload
    assign eq_01 = (hart_req_i[0] == hart_req_i[1]);
    assign eq_12 = (hart_req_i[1] == hart_req_i[2]);
    assign eq_02 = (hart_req_i[0] == hart_req_i[2]);

    assign tmr_mode = (mode_i == safe_bus_pkg::MODE_TMR);

    // Hart 0 wins unless only harts 1 and 2 agree
    always_comb begin
        if (eq_12 && !eq_01) begin
            chk.tmr_req = hart_req_i[1];
        end else begin
            chk.tmr_req = hart_req_i[0];
        end
    end

    // One-hot on the odd hart out, zero when all agree or all differ
    always_comb begin
        error_id = 3'b000;
        if (eq_12 && !eq_01) begin
            error_id = 3'b001;
        end else if (eq_02 && !eq_01) begin
            error_id = 3'b010;
        end else if (eq_01 && !eq_02) begin
            error_id = 3'b100;
        end
    end

    assign chk.tmr_error    = tmr_mode && !(eq_01 && eq_12);
    assign chk.tmr_error_id = tmr_mode ? error_id : 3'b000;

endmodule

// File: hdl/lockstep_delay.sv
/*
 * Shift register delaying the DMR lead request by NCYCLES clock edges
 */
`timescale 1ns/1ps

module lockstep_delay #(
    parameter int NCYCLES = 1
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  safe_bus_pkg::obi_req_t req_i,
    input  logic                   enable_i,
    output safe_bus_pkg::obi_req_t req_o
);

    // Stage 0 is the youngest entry
    safe_bus_pkg::obi_req_t [NCYCLES-1:0] stage_q;

    // Runs free of gnt, both harts of the pair stall alike
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stage_q <= '0;
        end else begin
            // Outside DMR only idle requests enter the line
            if (enable_i) begin
                stage_q[0] <= req_i;
            end else begin
                stage_q[0] <= '0;
            end
            for (int i = 1; i < NCYCLES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign req_o = stage_q[NCYCLES-1];

endmodule

// File: hdl/redundancy_if.sv
/*
 * Voter and comparator results on their way to the bus router
 */
`timescale 1ns/1ps

interface redundancy_if;

    safe_bus_pkg::obi_req_t tmr_req;
    logic                   tmr_error;
    logic [2:0]             tmr_error_id;
    // Lead request after the lockstep delay
    safe_bus_pkg::obi_req_t dmr_req;
    logic                   dmr_error;

    modport voter_mp (
        output tmr_req,
        output tmr_error,
        output tmr_error_id
    );

    modport comparator_mp (
        output dmr_req,
        output dmr_error
    );

    modport router_mp (
        input tmr_req,
        input tmr_error,
        input tmr_error_id,
        input dmr_req,
        input dmr_error
    );

endinterface

// File: hdl/safe_bus_pkg.sv
/*
 * Shared widths, OBI request/response structs, safety mode and DMR pair
 * enums, and pair decoding helpers for the bus safety fabric
 */
package safe_bus_pkg;

    // Vote needs exactly three harts
    localparam int NHARTS     = 3;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH   = 4;

    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [BE_WIDTH-1:0]   be;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } obi_req_t;

    typedef struct packed {
        logic                  gnt;
        logic                  rvalid;
        logic [DATA_WIDTH-1:0] rdata;
    } obi_rsp_t;

    // Unused code 2'b11 falls back to independent
    typedef enum logic [1:0] {
        MODE_INDEPENDENT = 2'd0,
        MODE_TMR         = 2'd1,
        MODE_DMR         = 2'd2
    } safety_mode_e;

    // Lower hart index of a pair is the lead, code 2'b11 acts as PAIR_01
    typedef enum logic [1:0] {
        PAIR_01 = 2'd0,
        PAIR_12 = 2'd1,
        PAIR_02 = 2'd2
    } dmr_pair_e;

    function automatic logic [1:0] pair_lead(dmr_pair_e pair);
        case (pair)
            PAIR_12: return 2'd1;
            default: return 2'd0;
        endcase
    endfunction

    function automatic logic [1:0] pair_shadow(dmr_pair_e pair);
        case (pair)
            PAIR_12, PAIR_02: return 2'd2;
            default:          return 2'd1;
        endcase
    endfunction

endpackage
